/* hdl/mips_isa_pkg.sv */
// ####################################################################
// instruction-set constants and field types of the integer subset
// import into the decoder, the execute stage and the testbench
// ####################################################################

package mips_isa_pkg;

    // data, address and register index widths
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // jal always links into r31
    localparam reg_idx_t LINK_REG = 5'd31;
    // no delay slot, so the next instruction is one word on
    localparam word_t    PC_STEP  = 32'd4;

    // opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] OP_REGIMM = 6'h01;
    localparam logic [5:0] OP_J      = 6'h02;
    localparam logic [5:0] OP_JAL    = 6'h03;
    localparam logic [5:0] OP_BEQ    = 6'h04;
    localparam logic [5:0] OP_BNE    = 6'h05;
    localparam logic [5:0] OP_BLEZ   = 6'h06;
    localparam logic [5:0] OP_BGTZ   = 6'h07;
    localparam logic [5:0] OP_ADDI   = 6'h08;
    localparam logic [5:0] OP_ADDIU  = 6'h09;
    localparam logic [5:0] OP_SLTI   = 6'h0a;
    localparam logic [5:0] OP_SLTIU  = 6'h0b;
    localparam logic [5:0] OP_ANDI   = 6'h0c;
    localparam logic [5:0] OP_ORI    = 6'h0d;
    localparam logic [5:0] OP_XORI   = 6'h0e;
    localparam logic [5:0] OP_LUI    = 6'h0f;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // REGIMM selector in the rt field
    localparam reg_idx_t RT_BLTZ = 5'h00;
    localparam reg_idx_t RT_BGEZ = 5'h01;

endpackage

/* hdl/exec_ctrl_pkg.sv */
// ####################################################################
// control encodings passed from decode to execute and writeback
// ####################################################################

package exec_ctrl_pkg;

    // ALU operation, picked by decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // branch kind, resolved in execute
    // nine kinds, so the field needs four bits
    typedef enum logic [3:0] {
        BR_NONE,
        BR_J,
        BR_REG,
        BR_EQ,
        BR_NE,
        BR_LEZ,
        BR_GTZ,
        BR_GEZ,
        BR_LTZ
    } br_kind_t;

    // second ALU operand: rt value or extended immediate
    typedef enum logic {
        SRC_B_RT,
        SRC_B_IMM
    } src_b_t;

endpackage

/* hdl/mips_decode.sv */
// ####################################################################
// decode stage that accepts one request and splits the instruction
// into fields and control, registered for the execute stage
// ####################################################################

module mips_decode (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_req,
    input  mips_isa_pkg::word_t     i_instr,
    input  mips_isa_pkg::word_t     i_pc,
    input  mips_isa_pkg::word_t     i_rs_val,
    input  mips_isa_pkg::word_t     i_rt_val,
    input  logic                    i_idle,
    output logic                    o_valid,
    output mips_isa_pkg::word_t     o_pc,
    output mips_isa_pkg::word_t     o_a,
    output mips_isa_pkg::word_t     o_b,
    output mips_isa_pkg::word_t     o_imm,
    output logic [4:0]              o_shamt,
    output exec_ctrl_pkg::alu_op_t  o_alu_op,
    output exec_ctrl_pkg::src_b_t   o_src_b,
    output exec_ctrl_pkg::br_kind_t o_br_kind,
    output mips_isa_pkg::reg_idx_t  o_target,
    output logic                    o_reg_write,
    output logic                    o_link,
    output logic                    o_ovf_en,
    output logic                    o_illegal
);
    import mips_isa_pkg::*;
    import exec_ctrl_pkg::*;

    // instruction fields
    logic [5:0] op;
    logic [5:0] funct;
    reg_idx_t   rt_idx;
    reg_idx_t   rd_idx;
    word_t      imm_sext;
    word_t      imm_zext;

    // decoded control ahead of the stage register
    alu_op_t    alu_op;
    src_b_t     src_b;
    br_kind_t   br_kind;
    reg_idx_t   target;
    word_t      imm;
    logic       reg_write;
    logic       link;
    logic       ovf_en;
    logic       illegal;

    logic       accept;
    logic       accepted_q;

    assign op       = i_instr[31:26];
    assign funct    = i_instr[5:0];
    assign rt_idx   = i_instr[20:16];
    assign rd_idx   = i_instr[15:11];
    assign imm_sext = {{16{i_instr[15]}}, i_instr[15:0]};
    assign imm_zext = {16'h0000, i_instr[15:0]};

    // skip the cycle right after an accept
    // since writeback only learns of it two cycles later
    assign accept = i_req && i_idle && !accepted_q;

    always_comb begin
        alu_op    = ALU_ADD;
        src_b     = SRC_B_IMM;
        br_kind   = BR_NONE;
        target    = rt_idx;
        imm       = imm_sext;
        reg_write = 1'b1;
        link      = 1'b0;
        ovf_en    = 1'b0;
        illegal   = 1'b0;
        case (op)
            OP_RTYPE: begin
                src_b  = SRC_B_RT;
                target = rd_idx;
                case (funct)
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_ADD:  ovf_en = 1'b1;
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB: begin
                        alu_op = ALU_SUB;
                        ovf_en = 1'b1;
                    end
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_JR: begin
                        br_kind   = BR_REG;
                        reg_write = 1'b0;
                    end
                    // jalr links into rd
                    FN_JALR: begin
                        br_kind = BR_REG;
                        link    = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OP_REGIMM: begin
                reg_write = 1'b0;
                if (rt_idx == RT_BGEZ) begin
                    br_kind = BR_GEZ;
                end else if (rt_idx == RT_BLTZ) begin
                    br_kind = BR_LTZ;
                end else begin
                    illegal = 1'b1;
                end
            end
            // jump index rides in the immediate field
            OP_J, OP_JAL: begin
                br_kind   = BR_J;
                imm       = {6'b000000, i_instr[25:0]};
                reg_write = (op == OP_JAL);
                link      = (op == OP_JAL);
                target    = LINK_REG;
            end
            OP_BEQ:   br_kind = BR_EQ;
            OP_BNE:   br_kind = BR_NE;
            OP_BLEZ:  br_kind = BR_LEZ;
            OP_BGTZ:  br_kind = BR_GTZ;
            OP_ADDI:  ovf_en  = 1'b1;
            OP_ADDIU: alu_op  = ALU_ADD;
            OP_SLTI:  alu_op  = ALU_SLT;
            OP_SLTIU: alu_op  = ALU_SLTU;
            OP_ANDI: begin
                alu_op = ALU_AND;
                imm    = imm_zext;
            end
            OP_ORI: begin
                alu_op = ALU_OR;
                imm    = imm_zext;
            end
            OP_XORI: begin
                alu_op = ALU_XOR;
                imm    = imm_zext;
            end
            OP_LUI:   alu_op = ALU_LUI;
            default:  illegal = 1'b1;
        endcase
        // conditional branches never write a register
        if (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ}) begin
            reg_write = 1'b0;
        end
        // reserved encodings fall through to pc+4 with no write
        if (illegal) begin
            br_kind   = BR_NONE;
            reg_write = 1'b0;
            link      = 1'b0;
            ovf_en    = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid    <= 1'b0;
            accepted_q <= 1'b0;
        end else begin
            o_valid    <= accept;
            accepted_q <= accept;
        end
    end

    // fields are held until the next accept because writeback reads o_pc late
    always_ff @(posedge clk) begin
        if (accept) begin
            o_pc        <= i_pc;
            o_a         <= i_rs_val;
            o_b         <= i_rt_val;
            o_imm       <= imm;
            o_shamt     <= i_instr[10:6];
            o_alu_op    <= alu_op;
            o_src_b     <= src_b;
            o_br_kind   <= br_kind;
            o_target    <= target;
            o_reg_write <= reg_write;
            o_link      <= link;
            o_ovf_en    <= ovf_en;
            o_illegal   <= illegal;
        end
    end

    // each valid pulse stands alone with no other pulse in the two cycles before it
    // the second cycle back relies on writeback going busy in time
    a_valid_pulse: assert property (@(posedge clk) disable iff (i_reset)
        o_valid |-> !$past(o_valid) && !$past(o_valid, 2));

endmodule

/* hdl/mips_execute.sv */
// ####################################################################
// execute stage: ALU, overflow check and branch resolution, registered
// ####################################################################

module mips_execute (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  mips_isa_pkg::word_t     i_pc,
    input  mips_isa_pkg::word_t     i_a,
    input  mips_isa_pkg::word_t     i_b,
    input  mips_isa_pkg::word_t     i_imm,
    input  logic [4:0]              i_shamt,
    input  exec_ctrl_pkg::alu_op_t  i_alu_op,
    input  exec_ctrl_pkg::src_b_t   i_src_b,
    input  exec_ctrl_pkg::br_kind_t i_br_kind,
    input  mips_isa_pkg::reg_idx_t  i_target,
    input  logic                    i_reg_write,
    input  logic                    i_link,
    input  logic                    i_ovf_en,
    input  logic                    i_illegal,
    output logic                    o_valid,
    output mips_isa_pkg::word_t     o_value,
    output mips_isa_pkg::word_t     o_next_pc,
    output mips_isa_pkg::reg_idx_t  o_target,
    output logic                    o_reg_write,
    output logic                    o_link,
    output logic                    o_overflow,
    output logic                    o_illegal
);
    import mips_isa_pkg::*;
    import exec_ctrl_pkg::*;

    word_t b_op;
    word_t sum;
    word_t diff;
    word_t alu_res;
    logic  ovf;
    logic  overflow;

    word_t pc_plus4;
    word_t br_pc;
    word_t j_pc;
    word_t next_pc;
    logic  taken;

    assign b_op = (i_src_b == SRC_B_IMM) ? i_imm : i_b;
    assign sum  = i_a + b_op;
    assign diff = i_a - b_op;

    always_comb begin
        case (i_alu_op)
            ALU_SUB:  alu_res = diff;
            ALU_AND:  alu_res = i_a & b_op;
            ALU_OR:   alu_res = i_a | b_op;
            ALU_XOR:  alu_res = i_a ^ b_op;
            ALU_NOR:  alu_res = ~(i_a | b_op);
            // shifts act on rt by shamt
            ALU_SLL:  alu_res = b_op << i_shamt;
            ALU_SRL:  alu_res = b_op >> i_shamt;
            ALU_SRA:  alu_res = $signed(b_op) >>> i_shamt;
            ALU_LUI:  alu_res = {b_op[15:0], 16'h0000};
            ALU_SLT:  alu_res = {31'd0, $signed(i_a) < $signed(b_op)};
            ALU_SLTU: alu_res = {31'd0, i_a < b_op};
            default:  alu_res = sum;
        endcase
    end

    // signed overflow: operand signs agree (add) or differ (sub)
    // and the result sign differs from a
    always_comb begin
        if (i_alu_op == ALU_SUB) begin
            ovf = (i_a[31] != b_op[31]) && (diff[31] != i_a[31]);
        end else begin
            ovf = (i_a[31] == b_op[31]) && (sum[31] != i_a[31]);
        end
    end
    assign overflow = i_ovf_en && ovf;

    // branch targets, no delay slot
    assign pc_plus4 = i_pc + PC_STEP;
    assign br_pc    = pc_plus4 + {i_imm[29:0], 2'b00};
    assign j_pc     = {i_pc[31:28], i_imm[25:0], 2'b00};

    // conditions look at rs, and at rt for eq/ne
    always_comb begin
        case (i_br_kind)
            BR_EQ:   taken = (i_a == i_b);
            BR_NE:   taken = (i_a != i_b);
            BR_LEZ:  taken = i_a[31] || (i_a == '0);
            BR_GTZ:  taken = !i_a[31] && (i_a != '0);
            BR_GEZ:  taken = !i_a[31];
            BR_LTZ:  taken = i_a[31];
            default: taken = 1'b0;
        endcase
        if (i_br_kind == BR_J) begin
            next_pc = j_pc;
        end else if (i_br_kind == BR_REG) begin
            next_pc = i_a;
        end else begin
            next_pc = taken ? br_pc : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_value     <= alu_res;
            o_next_pc   <= next_pc;
            o_target    <= i_target;
            // overflowing add/sub must not reach the register file
            o_reg_write <= i_reg_write && !overflow;
            o_link      <= i_link;
            o_overflow  <= overflow;
            o_illegal   <= i_illegal;
        end
    end

endmodule

/* hdl/mips_writeback.sv */
// ####################################################################
// writeback stage: picks the result, holds outputs and drives o_ack
// ####################################################################

module mips_writeback (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  mips_isa_pkg::word_t    i_value,
    input  mips_isa_pkg::word_t    i_next_pc,
    input  mips_isa_pkg::word_t    i_pc,
    input  mips_isa_pkg::reg_idx_t i_target,
    input  logic                   i_reg_write,
    input  logic                   i_link,
    input  logic                   i_overflow,
    input  logic                   i_illegal,
    input  logic                   i_req,
    output logic                   o_idle,
    output logic                   o_ack,
    output mips_isa_pkg::word_t    o_result,
    output mips_isa_pkg::word_t    o_next_pc,
    output mips_isa_pkg::reg_idx_t o_target_reg,
    output logic                   o_reg_write,
    output logic                   o_overflow,
    output logic                   o_illegal
);
    import mips_isa_pkg::*;

    word_t link_pc;
    logic  idle_q;

    // jal/jalr return address
    assign link_pc = i_pc + PC_STEP;

    // drop idle already while the result is on its way in
    assign o_idle = idle_q && !i_valid;

    // four-phase: ack up on capture, down once req is seen low
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ack  <= 1'b0;
            idle_q <= 1'b1;
        end else if (i_valid) begin
            o_ack  <= 1'b1;
            idle_q <= 1'b0;
        end else if (o_ack && !i_req) begin
            o_ack  <= 1'b0;
            idle_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_result     <= i_link ? link_pc : i_value;
            o_next_pc    <= i_next_pc;
            o_target_reg <= i_target;
            o_reg_write  <= i_reg_write;
            o_overflow   <= i_overflow;
            o_illegal    <= i_illegal;
        end
    end

    // an ack only ever answers a pending request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (i_reset)
        $rose(o_ack) |-> i_req);

endmodule

/* hdl/exec_unit_top.sv */
// ####################################################################
// single-instruction execute unit, decode -> execute -> writeback
// ####################################################################

module exec_unit_top (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_req,
    input  mips_isa_pkg::word_t    i_instr,
    input  mips_isa_pkg::word_t    i_pc,
    input  mips_isa_pkg::word_t    i_rs_val,
    input  mips_isa_pkg::word_t    i_rt_val,
    output logic                   o_ack,
    output mips_isa_pkg::word_t    o_result,
    output mips_isa_pkg::word_t    o_next_pc,
    output mips_isa_pkg::reg_idx_t o_target_reg,
    output logic                   o_reg_write,
    output logic                   o_overflow,
    output logic                   o_illegal
);
    import mips_isa_pkg::*;
    import exec_ctrl_pkg::*;

    // decode -> execute
    logic     dec_valid;
    word_t    dec_pc;
    word_t    dec_a;
    word_t    dec_b;
    word_t    dec_imm;
    logic [4:0] dec_shamt;
    alu_op_t  dec_alu_op;
    src_b_t   dec_src_b;
    br_kind_t dec_br_kind;
    reg_idx_t dec_target;
    logic     dec_reg_write;
    logic     dec_link;
    logic     dec_ovf_en;
    logic     dec_illegal;

    // execute -> writeback
    logic     exe_valid;
    word_t    exe_value;
    word_t    exe_next_pc;
    reg_idx_t exe_target;
    logic     exe_reg_write;
    logic     exe_link;
    logic     exe_overflow;
    logic     exe_illegal;

    // writeback -> decode
    logic     wb_idle;

    mips_decode u_decode (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .i_instr     (i_instr),
        .i_pc        (i_pc),
        .i_rs_val    (i_rs_val),
        .i_rt_val    (i_rt_val),
        .i_idle      (wb_idle),
        .o_valid     (dec_valid),
        .o_pc        (dec_pc),
        .o_a         (dec_a),
        .o_b         (dec_b),
        .o_imm       (dec_imm),
        .o_shamt     (dec_shamt),
        .o_alu_op    (dec_alu_op),
        .o_src_b     (dec_src_b),
        .o_br_kind   (dec_br_kind),
        .o_target    (dec_target),
        .o_reg_write (dec_reg_write),
        .o_link      (dec_link),
        .o_ovf_en    (dec_ovf_en),
        .o_illegal   (dec_illegal)
    );

    mips_execute u_execute (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_valid     (dec_valid),
        .i_pc        (dec_pc),
        .i_a         (dec_a),
        .i_b         (dec_b),
        .i_imm       (dec_imm),
        .i_shamt     (dec_shamt),
        .i_alu_op    (dec_alu_op),
        .i_src_b     (dec_src_b),
        .i_br_kind   (dec_br_kind),
        .i_target    (dec_target),
        .i_reg_write (dec_reg_write),
        .i_link      (dec_link),
        .i_ovf_en    (dec_ovf_en),
        .i_illegal   (dec_illegal),
        .o_valid     (exe_valid),
        .o_value     (exe_value),
        .o_next_pc   (exe_next_pc),
        .o_target    (exe_target),
        .o_reg_write (exe_reg_write),
        .o_link      (exe_link),
        .o_overflow  (exe_overflow),
        .o_illegal   (exe_illegal)
    );

    // decode holds its pc until the next accept, so it serves the link value
    mips_writeback u_writeback (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (exe_valid),
        .i_value      (exe_value),
        .i_next_pc    (exe_next_pc),
        .i_pc         (dec_pc),
        .i_target     (exe_target),
        .i_reg_write  (exe_reg_write),
        .i_link       (exe_link),
        .i_overflow   (exe_overflow),
        .i_illegal    (exe_illegal),
        .i_req        (i_req),
        .o_idle       (wb_idle),
        .o_ack        (o_ack),
        .o_result     (o_result),
        .o_next_pc    (o_next_pc),
        .o_target_reg (o_target_reg),
        .o_reg_write  (o_reg_write),
        .o_overflow   (o_overflow),
        .o_illegal    (o_illegal)
    );

endmodule

/* tb/exec_unit_tb.sv */
// ######################################################################
// testbench for the execute unit that runs a table of instructions
// through the four-phase handshake and compares every result with it
// ######################################################################

module exec_unit_tb;
    import mips_isa_pkg::*;

    // clocks to wait for any o_ack edge before giving up
    localparam int WAIT_LIMIT = 20;

    // one table entry with inputs followed by expected outputs
    typedef struct packed {
        word_t    instr;
        word_t    pc;
        word_t    rs;
        word_t    rt;
        word_t    result;
        word_t    next_pc;
        reg_idx_t target;
        logic     reg_write;
        logic     overflow;
        logic     illegal;
    } vec_t;

    logic     clk = 1'b0;
    logic     i_reset;
    logic     i_req;
    word_t    i_instr;
    word_t    i_pc;
    word_t    i_rs_val;
    word_t    i_rt_val;
    logic     o_ack;
    word_t    o_result;
    word_t    o_next_pc;
    reg_idx_t o_target_reg;
    logic     o_reg_write;
    logic     o_overflow;
    logic     o_illegal;

    vec_t        table_q[$];
    logic [15:0] lfsr_state;

    always #4 clk = ~clk;

    exec_unit_top DUT (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_req        (i_req),
        .i_instr      (i_instr),
        .i_pc         (i_pc),
        .i_rs_val     (i_rs_val),
        .i_rt_val     (i_rt_val),
        .o_ack        (o_ack),
        .o_result     (o_result),
        .o_next_pc    (o_next_pc),
        .o_target_reg (o_target_reg),
        .o_reg_write  (o_reg_write),
        .o_overflow   (o_overflow),
        .o_illegal    (o_illegal)
    );

    // instruction encoders
    function automatic word_t rtype(input logic [5:0] fn, input int rs, input int rt,
                                    input int rd, input int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input int rs, input int rt,
                                    input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t jtype(input logic [5:0] op, input int idx);
        return {op, idx[25:0]};
    endfunction

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int val);
        int k;
        val = 0;
        for (k = 0; k < n; k = k + 1) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = val * 2;
            if (lfsr_state[0]) begin
                val = val + 1;
            end
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR at time %0t: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR at time %0t: %s is %0d, expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR at time %0t: %s is %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    // flags are {reg_write, overflow, illegal}
    task automatic add_vec(input word_t instr, input word_t pc, input word_t rs,
                           input word_t rt, input word_t result, input word_t next_pc,
                           input int target, input logic [2:0] flags);
        vec_t v;
        v.instr     = instr;
        v.pc        = pc;
        v.rs        = rs;
        v.rt        = rt;
        v.result    = result;
        v.next_pc   = next_pc;
        v.target    = target[4:0];
        v.reg_write = flags[2];
        v.overflow  = flags[1];
        v.illegal   = flags[0];
        table_q.push_back(v);
    endtask

    // result and target only mean something when a register is written
    task automatic build_table();
        // arithmetic and logic
        add_vec(rtype(FN_ADD, 1, 2, 3, 0), 'h400000, 'h5, 'h7, 'hc, 'h400004, 3, 3'b100);
        add_vec(rtype(FN_ADDU, 1, 2, 4, 0), 'h400004, 'hffffffff, 'h2,
                'h1, 'h400008, 4, 3'b100);
        add_vec(rtype(FN_SUB, 1, 2, 5, 0), 'h400008, 'h3, 'ha,
                'hfffffff9, 'h40000c, 5, 3'b100);
        add_vec(rtype(FN_SUBU, 1, 2, 6, 0), 'h40000c, 'h0, 'h1,
                'hffffffff, 'h400010, 6, 3'b100);
        add_vec(rtype(FN_AND, 1, 2, 7, 0), 'h400010, 'hf0f01234, 'h0ff0ff00,
                'h00f01200, 'h400014, 7, 3'b100);
        add_vec(rtype(FN_OR, 1, 2, 8, 0), 'h400014, 'hf0f01234, 'h0ff0ff00,
                'hfff0ff34, 'h400018, 8, 3'b100);
        add_vec(rtype(FN_XOR, 1, 2, 9, 0), 'h400018, 'hf0f01234, 'h0ff0ff00,
                'hff00ed34, 'h40001c, 9, 3'b100);
        add_vec(rtype(FN_NOR, 1, 2, 10, 0), 'h40001c, 'hf0f01234, 'h0ff0ff00,
                'h000f00cb, 'h400020, 10, 3'b100);
        // logic immediates are zero-extended
        add_vec(itype(OP_ANDI, 1, 11, 'h8001), 'h400020, 'hffffffff, 'h0,
                'h8001, 'h400024, 11, 3'b100);
        add_vec(itype(OP_ORI, 1, 12, 'h8765), 'h400024, 'h12340000, 'h0,
                'h12348765, 'h400028, 12, 3'b100);
        add_vec(itype(OP_XORI, 1, 13, 'hff00), 'h400028, 'hffff, 'h0,
                'hff, 'h40002c, 13, 3'b100);
        add_vec(itype(OP_ADDIU, 1, 14, 'hffff), 'h40002c, 'h10, 'h0,
                'hf, 'h400030, 14, 3'b100);
        add_vec(itype(OP_LUI, 0, 15, 'hbeef), 'h400030, 'h0, 'h0,
                'hbeef0000, 'h400034, 15, 3'b100);
        add_vec(itype(OP_ADDI, 1, 16, 'hfffd), 'h400034, 'h5, 'h0, 'h2, 'h400038, 16, 3'b100);
        // shifts by shamt and compares signed and unsigned
        add_vec(rtype(FN_SLL, 0, 2, 17, 4), 'h400038, 'h0, 'h80000001,
                'h10, 'h40003c, 17, 3'b100);
        add_vec(rtype(FN_SRL, 0, 2, 18, 31), 'h40003c, 'h0, 'h80000000,
                'h1, 'h400040, 18, 3'b100);
        add_vec(rtype(FN_SRA, 0, 2, 19, 4), 'h400040, 'h0, 'h80000000,
                'hf8000000, 'h400044, 19, 3'b100);
        add_vec(rtype(FN_SLT, 1, 2, 20, 0), 'h400044, 'hffffffff, 'h1,
                'h1, 'h400048, 20, 3'b100);
        add_vec(rtype(FN_SLT, 1, 2, 21, 0), 'h400048, 'h1, 'hffffffff,
                'h0, 'h40004c, 21, 3'b100);
        add_vec(rtype(FN_SLTU, 1, 2, 22, 0), 'h40004c, 'hffffffff, 'h1,
                'h0, 'h400050, 22, 3'b100);
        add_vec(itype(OP_SLTI, 1, 23, 'hffff), 'h400050, 'hfffffffe, 'h0,
                'h1, 'h400054, 23, 3'b100);
        add_vec(itype(OP_SLTIU, 1, 24, 'hffff), 'h400054, 'h1, 'h0, 'h1, 'h400058, 24, 3'b100);
        // overflow traps add, addi and sub but not addu
        add_vec(rtype(FN_ADD, 1, 2, 3, 0), 'h400058, 'h7fffffff, 'h1,
                'h0, 'h40005c, 3, 3'b010);
        add_vec(rtype(FN_ADDU, 1, 2, 3, 0), 'h40005c, 'h7fffffff, 'h1,
                'h80000000, 'h400060, 3, 3'b100);
        add_vec(itype(OP_ADDI, 1, 4, 'hffff), 'h400060, 'h80000000, 'h0,
                'h0, 'h400064, 4, 3'b010);
        add_vec(rtype(FN_SUB, 1, 2, 5, 0), 'h400064, 'h80000000, 'h1,
                'h0, 'h400068, 5, 3'b010);
        // conditional branches taken then not taken
        add_vec(itype(OP_BEQ, 1, 2, 'h10), 'h400100, 'h9, 'h9, 'h0, 'h400144, 0, 3'b000);
        add_vec(itype(OP_BEQ, 1, 2, 'h10), 'h400100, 'h9, 'h8, 'h0, 'h400104, 0, 3'b000);
        add_vec(itype(OP_BNE, 1, 2, 'hfffe), 'h400200, 'h1, 'h2, 'h0, 'h4001fc, 0, 3'b000);
        add_vec(itype(OP_BNE, 1, 2, 'hfffe), 'h400200, 'h2, 'h2, 'h0, 'h400204, 0, 3'b000);
        add_vec(itype(OP_BLEZ, 1, 0, 'h4), 'h400300, 'h0, 'h0, 'h0, 'h400314, 0, 3'b000);
        add_vec(itype(OP_BLEZ, 1, 0, 'h4), 'h400300, 'h1, 'h0, 'h0, 'h400304, 0, 3'b000);
        add_vec(itype(OP_BGTZ, 1, 0, 'h1), 'h400400, 'h5, 'h0, 'h0, 'h400408, 0, 3'b000);
        add_vec(itype(OP_BGTZ, 1, 0, 'h1), 'h400400, 'h80000000, 'h0,
                'h0, 'h400404, 0, 3'b000);
        add_vec(itype(OP_REGIMM, 1, 1, 'hffff), 'h400500, 'h0, 'h0, 'h0, 'h400500, 0, 3'b000);
        add_vec(itype(OP_REGIMM, 1, 1, 'hffff), 'h400500, 'hffffffff, 'h0,
                'h0, 'h400504, 0, 3'b000);
        add_vec(itype(OP_REGIMM, 1, 0, 'h2), 'h400600, 'hffffffff, 'h0,
                'h0, 'h40060c, 0, 3'b000);
        add_vec(itype(OP_REGIMM, 1, 0, 'h2), 'h400600, 'h0, 'h0, 'h0, 'h400604, 0, 3'b000);
        // jumps with the link value at pc+4 and no delay slot
        add_vec(jtype(OP_J, 'h123456), 'ha0000010, 'h0, 'h0, 'h0, 'ha048d158, 0, 3'b000);
        add_vec(jtype(OP_JAL, 'h3ffffff), 'h10000020, 'h0, 'h0,
                'h10000024, 'h1ffffffc, 31, 3'b100);
        add_vec(rtype(FN_JR, 1, 0, 0, 0), 'h400700, 'h400800, 'h0, 'h0, 'h400800, 0, 3'b000);
        add_vec(rtype(FN_JALR, 1, 0, 5, 0), 'h400710, 'h400900, 'h0,
                'h400714, 'h400900, 5, 3'b100);
        // reserved opcode and reserved function code
        add_vec('hfc000000, 'h400800, 'h0, 'h0, 'h0, 'h400804, 0, 3'b001);
        add_vec(rtype(6'h3f, 1, 2, 3, 0), 'h400804, 'h0, 'h0, 'h0, 'h400808, 0, 3'b001);
    endtask

    task automatic check_outputs(input vec_t v);
        check_word("o_next_pc", o_next_pc, v.next_pc);
        check_flag("o_reg_write", o_reg_write, v.reg_write);
        check_flag("o_overflow", o_overflow, v.overflow);
        check_flag("o_illegal", o_illegal, v.illegal);
        if (v.reg_write) begin
            check_word("o_result", o_result, v.result);
            check_reg("o_target_reg", o_target_reg, v.target);
        end
    endtask

    task automatic drive_idle();
        i_reset  <= 1'b1;
        i_req    <= 1'b0;
        i_instr  <= '0;
        i_pc     <= '0;
        i_rs_val <= '0;
        i_rt_val <= '0;
    endtask

    // one full four-phase transfer with outputs sampled at the falling edge
    task automatic run_vec(input vec_t v);
        int   cycles;
        logic done;
        @(posedge clk);
        i_instr  <= v.instr;
        i_pc     <= v.pc;
        i_rs_val <= v.rs;
        i_rt_val <= v.rt;
        i_req    <= 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (o_ack === 1'b1) begin
                done = 1'b1;
            end else if (cycles >= WAIT_LIMIT) begin
                fail_now("timeout: o_ack never rose after i_req was raised");
            end
        end
        // first negedge falls before the edge that samples i_req
        if (cycles != 4) begin
            fail_now($sformatf("o_ack rose %0d clocks after i_req was sampled, expected 3",
                               cycles - 1));
        end
        check_outputs(v);
        // hold the request a little longer while ack and outputs stay put
        @(negedge clk);
        check_flag("o_ack", o_ack, 1'b1);
        check_outputs(v);
        @(posedge clk);
        i_req <= 1'b0;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (o_ack === 1'b0) begin
                done = 1'b1;
            end else if (cycles >= WAIT_LIMIT) begin
                fail_now("timeout: o_ack never fell after i_req was dropped");
            end
        end
        if (cycles != 2) begin
            fail_now("o_ack did not fall on the first edge that sampled i_req low");
        end
    endtask

    initial begin
        int gap;
        lfsr_state = 16'd15868;
        drive_idle();
        build_table();
        repeat (2) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_flag("o_ack", o_ack, 1'b0);
        foreach (table_q[k]) begin
            run_vec(table_q[k]);
            // random pause of 0 to 3 clocks between requests
            take_bits(2, gap);
            repeat (gap) @(posedge clk);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
hdl/mips_isa_pkg.sv
hdl/exec_ctrl_pkg.sv
hdl/mips_decode.sv
hdl/mips_execute.sv
hdl/mips_writeback.sv
hdl/exec_unit_top.sv
tb/exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the log

verilator --binary --assert -f project.f --top-module exec_unit_tb -o exec_unit_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/exec_unit_sim > sim.log 2>&1
cat sim.log

grep -qF '*** TEST FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log || { echo "simulation ended without a verdict"; exit 1; }

echo "simulation passed"
exit 0
